//--- verilog/decode_pkg.sv
/*
 * Shared types for the RV32I decode and issue stage
 * Widths, unit indices, funct3 codes, opcode and ALU enums,
 * and the packed structs passed between the stage blocks
 */
package decode_pkg;

    //////////////////////////////////////////////////
    // Widths
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [20:0] pc_offset_t;
    typedef logic [11:0] ls_offset_t;
    typedef logic [2:0]  fn3_t;
    typedef logic [2:0]  unit_vec_t;

    // Bit positions in a unit vector
    localparam int ALU_UNIT = 0;
    localparam int BRANCH_UNIT = 1;
    localparam int LS_UNIT = 2;

    // funct3 codes
    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLL_FN3 = 3'b001;
    localparam fn3_t SLT_FN3 = 3'b010;
    localparam fn3_t SLTU_FN3 = 3'b011;
    localparam fn3_t XOR_FN3 = 3'b100;
    localparam fn3_t SR_FN3 = 3'b101;
    localparam fn3_t OR_FN3 = 3'b110;
    localparam fn3_t AND_FN3 = 3'b111;
    localparam fn3_t BLTU_FN3 = 3'b110;
    localparam fn3_t BGEU_FN3 = 3'b111;

    //////////////////////////////////////////////////
    // Encodings
    // Opcode bits [6:2], the low two bits are always 11
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011
    } opcode_trim_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11
    } alu_logic_op_t;

    //////////////////////////////////////////////////
    // Stage packets
    typedef struct packed {
        logic   valid;
        xlen_t  pc;
        instr_t instruction;
    } decode_packet_t;

    typedef struct packed {
        unit_vec_t     units;
        reg_addr_t     rs1_addr;
        reg_addr_t     rs2_addr;
        logic          uses_rs1;
        logic          uses_rs2;
        fn3_t          fn3;
        logic          opcode_5;
        xlen_t         alu_pre_rs1;
        xlen_t         alu_pre_rs2;
        logic          alu_rs1_use_reg;
        logic          alu_rs2_use_reg;
        alu_logic_op_t logic_op;
        logic          subtract;
        logic          slt_path;
        logic          shifter_path;
        logic          lshift;
        ls_offset_t    ls_offset;
        logic          load;
        logic          store;
        pc_offset_t    pc_offset;
        logic          jal;
        logic          jalr;
        logic          use_signed;
    } decoded_t;

    typedef struct packed {
        decoded_t decoded;
        xlen_t    pc;
        instr_t   instruction;
        logic     stage_valid;
    } issue_packet_t;

    //////////////////////////////////////////////////
    // Unit payloads
    typedef struct packed {
        logic [32:0]   in1;
        logic [32:0]   in2;
        xlen_t         shifter_in;
        logic [4:0]    shift_amount;
        alu_logic_op_t logic_op;
        logic          subtract;
        logic          arith;
        logic          lshift;
        logic          shifter_path;
        logic          slt_path;
    } alu_inputs_t;

    typedef struct packed {
        xlen_t      rs1;
        xlen_t      rs2;
        ls_offset_t offset;
        fn3_t       fn3;
        logic       load;
        logic       store;
        logic       forwarded_store;
    } ls_inputs_t;

    typedef struct packed {
        xlen_t      rs1;
        xlen_t      rs2;
        xlen_t      issue_pc;
        pc_offset_t pc_offset;
        fn3_t       fn3;
        logic       jal;
        logic       jalr;
        logic       use_signed;
    } branch_inputs_t;

endpackage

//--- verilog/instruction_decoder.sv
/*
 * RV32I instruction decoder
 * Field extraction, unit selection, ALU pre-operands and control bits,
 * load/store offset and branch pc offset
 */
module instruction_decoder (
    input  decode_pkg::instr_t   instruction,
    input  decode_pkg::xlen_t    pc,
    output decode_pkg::decoded_t decoded
);

    logic [6:0] opcode;
    decode_pkg::opcode_trim_t opcode_trim;
    decode_pkg::fn3_t fn3;
    logic upper_imm;
    logic jump;
    logic sub_instruction;
    decode_pkg::alu_logic_op_t logic_op;
    decode_pkg::xlen_t pre_rs2;
    logic [19:0] jal_imm;
    logic [11:0] br_imm;
    decode_pkg::pc_offset_t pc_offset;

    assign opcode = instruction[6:0];
    assign opcode_trim = decode_pkg::opcode_trim_t'(opcode[6:2]);
    assign fn3 = instruction[14:12];

    assign upper_imm = opcode_trim inside {decode_pkg::LUI_T, decode_pkg::AUIPC_T};
    assign jump = opcode_trim inside {decode_pkg::JAL_T, decode_pkg::JALR_T};

    //////////////////////////////////////////////////
    // Fields and units
    assign decoded.rs1_addr = instruction[19:15];
    assign decoded.rs2_addr = instruction[24:20];
    assign decoded.fn3 = fn3;
    // Register-register form, picks the shift amount source
    assign decoded.opcode_5 = opcode[5];

    assign decoded.units[decode_pkg::ALU_UNIT] = upper_imm | jump
        | (opcode_trim inside {decode_pkg::ARITH_T, decode_pkg::ARITH_IMM_T});
    assign decoded.units[decode_pkg::BRANCH_UNIT] = jump | (opcode_trim == decode_pkg::BRANCH_T);
    assign decoded.units[decode_pkg::LS_UNIT] =
        opcode_trim inside {decode_pkg::LOAD_T, decode_pkg::STORE_T};

    assign decoded.uses_rs1 = ~(upper_imm | (opcode_trim == decode_pkg::JAL_T));
    assign decoded.uses_rs2 = opcode_trim inside
        {decode_pkg::BRANCH_T, decode_pkg::STORE_T, decode_pkg::ARITH_T};

    //////////////////////////////////////////////////
    // ALU pre-operands and control
    always_comb begin
        if (upper_imm)
            pre_rs2 = {instruction[31:12], 12'b0};
        else if (jump)
            pre_rs2 = 32'd4;
        else
            pre_rs2 = 32'(signed'(instruction[31:20]));
    end

    assign decoded.alu_pre_rs2 = pre_rs2;
    // AUIPC, JAL and JALR add to the pc, LUI adds to zero
    assign decoded.alu_pre_rs1 = (jump | (opcode_trim == decode_pkg::AUIPC_T)) ? pc : '0;
    assign decoded.alu_rs1_use_reg = ~(upper_imm | jump);
    assign decoded.alu_rs2_use_reg = ~(upper_imm | jump | (opcode_trim == decode_pkg::ARITH_IMM_T));

    // SUB only exists in the register form
    assign sub_instruction = (fn3 == decode_pkg::ADD_SUB_FN3) & instruction[30] & opcode[5];

    always_comb begin
        case (fn3)
            decode_pkg::XOR_FN3: logic_op = decode_pkg::ALU_LOGIC_XOR;
            decode_pkg::OR_FN3:  logic_op = decode_pkg::ALU_LOGIC_OR;
            decode_pkg::AND_FN3: logic_op = decode_pkg::ALU_LOGIC_AND;
            default:             logic_op = decode_pkg::ALU_LOGIC_ADD;
        endcase
        // opcode[2] marks LUI, AUIPC, JAL and JALR, all on the adder
        if (opcode[2])
            logic_op = decode_pkg::ALU_LOGIC_ADD;
    end

    assign decoded.logic_op = logic_op;
    assign decoded.subtract = ~opcode[2]
        & (sub_instruction | (fn3 inside {decode_pkg::SLT_FN3, decode_pkg::SLTU_FN3}));
    assign decoded.slt_path = ~opcode[2] & (fn3 inside {decode_pkg::SLT_FN3, decode_pkg::SLTU_FN3});
    assign decoded.shifter_path = ~opcode[2] & (fn3 inside {decode_pkg::SLL_FN3, decode_pkg::SR_FN3});
    assign decoded.lshift = ~fn3[2];

    //////////////////////////////////////////////////
    // Load/store and branch fields
    assign decoded.ls_offset = opcode[5] ? {instruction[31:25], instruction[11:7]}
                                         : instruction[31:20];
    assign decoded.load = opcode_trim == decode_pkg::LOAD_T;
    assign decoded.store = opcode_trim == decode_pkg::STORE_T;

    assign jal_imm = {instruction[31], instruction[19:12], instruction[20], instruction[30:21]};
    assign br_imm = {instruction[31], instruction[7], instruction[30:25], instruction[11:8]};

    always_comb begin
        if (opcode_trim == decode_pkg::JALR_T)
            pc_offset = 21'(signed'(instruction[31:20]));
        else if (opcode_trim == decode_pkg::JAL_T)
            pc_offset = {jal_imm, 1'b0};
        else
            pc_offset = 21'(signed'({br_imm, 1'b0}));
    end

    assign decoded.pc_offset = pc_offset;
    assign decoded.jal = opcode_trim == decode_pkg::JAL_T;
    assign decoded.jalr = opcode_trim == decode_pkg::JALR_T;
    assign decoded.use_signed = ~(fn3 inside {decode_pkg::BLTU_FN3, decode_pkg::BGEU_FN3});

endmodule

//--- verilog/issue_stage.sv
/*
 * One-entry issue stage
 * Holds the decoded instruction, checks operand hazards and unit
 * readiness, and drives the issue and fetch handshakes
 */
module issue_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  decode_pkg::decode_packet_t decode,
    input  decode_pkg::decoded_t       decoded,
    output logic                       decode_advance,
    input  logic                       rs1_busy,
    input  logic                       rs2_busy,
    input  logic                       issue_hold,
    input  logic                       flush,
    input  decode_pkg::unit_vec_t      unit_ready,
    output decode_pkg::unit_vec_t      issue_to,
    output logic                       instruction_issued,
    output logic                       forwarded_store,
    output decode_pkg::issue_packet_t  issue
);

    logic stage_valid;
    decode_pkg::decoded_t held;
    decode_pkg::xlen_t held_pc;
    decode_pkg::instr_t held_instruction;

    logic stage_ready;
    logic issue_valid;
    logic rs1_conflict;
    logic rs2_conflict;
    decode_pkg::unit_vec_t operands_ok;
    decode_pkg::unit_vec_t unit_ok;

    //////////////////////////////////////////////////
    // Stage register
    // Loads when empty or when the held instruction leaves this cycle
    assign stage_ready = ~issue_hold & (~stage_valid | instruction_issued);
    assign decode_advance = decode.valid & stage_ready;

    always_ff @(posedge clk) begin
        if (rst | flush)
            stage_valid <= 1'b0;
        else if (stage_ready)
            stage_valid <= decode.valid;
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            held <= decoded;
            held_pc <= decode.pc;
            held_instruction <= decode.instruction;
        end
    end

    always_comb begin
        issue.decoded = held;
        issue.pc = held_pc;
        issue.instruction = held_instruction;
        issue.stage_valid = stage_valid;
    end

    //////////////////////////////////////////////////
    // Issue decision
    assign issue_valid = stage_valid & ~issue_hold & ~flush;

    // x0 never waits on a writer
    assign rs1_conflict = rs1_busy & held.uses_rs1 & (held.rs1_addr != '0);
    assign rs2_conflict = rs2_busy & held.uses_rs2 & (held.rs2_addr != '0);

    always_comb begin
        operands_ok = {$bits(decode_pkg::unit_vec_t){~rs1_conflict & ~rs2_conflict}};
        // Load/store picks up a late rs2 through its own forwarding path
        operands_ok[decode_pkg::LS_UNIT] = ~rs1_conflict;
    end

    // All needed units at once, units not needed count as ok
    assign unit_ok = ~held.units | (unit_ready & operands_ok);

    assign instruction_issued = issue_valid & (&unit_ok);
    assign issue_to = held.units & {$bits(decode_pkg::unit_vec_t){instruction_issued}};
    assign forwarded_store = rs2_conflict & held.store;

endmodule

//--- verilog/operand_builder.sv
/*
 * Operand builder
 * Forms the ALU, load/store and branch payloads from the held
 * instruction and the register file data
 */
module operand_builder (
    input  decode_pkg::issue_packet_t  issue,
    input  decode_pkg::xlen_t          rs1_data,
    input  decode_pkg::xlen_t          rs2_data,
    input  logic                       forwarded_store,
    output decode_pkg::alu_inputs_t    alu_inputs,
    output decode_pkg::ls_inputs_t     ls_inputs,
    output decode_pkg::branch_inputs_t branch_inputs
);

    decode_pkg::decoded_t dec;
    decode_pkg::xlen_t alu_rs1;
    decode_pkg::xlen_t alu_rs2;
    logic unsigned_cmp;

    assign dec = issue.decoded;

    //////////////////////////////////////////////////
    // ALU payload
    assign alu_rs1 = dec.alu_rs1_use_reg ? rs1_data : dec.alu_pre_rs1;
    assign alu_rs2 = dec.alu_rs2_use_reg ? rs2_data : dec.alu_pre_rs2;

    // fn3[0] set means SLTU, so no sign extension
    assign unsigned_cmp = dec.fn3[0];

    assign alu_inputs.in1 = {alu_rs1[31] & ~unsigned_cmp, alu_rs1};
    assign alu_inputs.in2 = {alu_rs2[31] & ~unsigned_cmp, alu_rs2};

    assign alu_inputs.shifter_in = rs1_data;
    // Register shifts use rs2 data, immediate shifts the shamt field
    assign alu_inputs.shift_amount = dec.opcode_5 ? rs2_data[4:0] : dec.rs2_addr;
    // Fill bit for SRA/SRAI
    assign alu_inputs.arith = rs1_data[31] & issue.instruction[30];

    assign alu_inputs.logic_op = dec.logic_op;
    assign alu_inputs.subtract = dec.subtract;
    assign alu_inputs.lshift = dec.lshift;
    assign alu_inputs.shifter_path = dec.shifter_path;
    assign alu_inputs.slt_path = dec.slt_path;

    //////////////////////////////////////////////////
    // Load/store payload
    assign ls_inputs.rs1 = rs1_data;
    assign ls_inputs.rs2 = rs2_data;
    assign ls_inputs.offset = dec.ls_offset;
    assign ls_inputs.fn3 = dec.fn3;
    assign ls_inputs.load = dec.load;
    assign ls_inputs.store = dec.store;
    assign ls_inputs.forwarded_store = forwarded_store;

    //////////////////////////////////////////////////
    // Branch payload
    assign branch_inputs.rs1 = rs1_data;
    assign branch_inputs.rs2 = rs2_data;
    assign branch_inputs.issue_pc = issue.pc;
    assign branch_inputs.pc_offset = dec.pc_offset;
    assign branch_inputs.fn3 = dec.fn3;
    assign branch_inputs.jal = dec.jal;
    assign branch_inputs.jalr = dec.jalr;
    assign branch_inputs.use_signed = dec.use_signed;

endmodule

//--- verilog/decode_issue.sv
/*
 * Decode and issue stage, top level
 * Decoder, one-entry issue stage and operand builder
 */
module decode_issue (
    input  logic                       clk,
    input  logic                       rst,
    input  decode_pkg::decode_packet_t decode,
    output logic                       decode_advance,
    input  decode_pkg::xlen_t          rs1_data,
    input  decode_pkg::xlen_t          rs2_data,
    input  logic                       rs1_busy,
    input  logic                       rs2_busy,
    input  decode_pkg::unit_vec_t      unit_ready,
    input  logic                       issue_hold,
    input  logic                       flush,
    output decode_pkg::unit_vec_t      issue_to,
    output logic                       instruction_issued,
    output decode_pkg::alu_inputs_t    alu_inputs,
    output decode_pkg::ls_inputs_t     ls_inputs,
    output decode_pkg::branch_inputs_t branch_inputs
);

    decode_pkg::decoded_t decoded;
    decode_pkg::issue_packet_t issue;
    logic forwarded_store;

    instruction_decoder decoder (
        .instruction (decode.instruction),
        .pc          (decode.pc),
        .decoded     (decoded)
    );

    issue_stage stage (
        .clk                (clk),
        .rst                (rst),
        .decode             (decode),
        .decoded            (decoded),
        .decode_advance     (decode_advance),
        .rs1_busy           (rs1_busy),
        .rs2_busy           (rs2_busy),
        .issue_hold         (issue_hold),
        .flush              (flush),
        .unit_ready         (unit_ready),
        .issue_to           (issue_to),
        .instruction_issued (instruction_issued),
        .forwarded_store    (forwarded_store),
        .issue              (issue)
    );

    // Payloads follow the held instruction
    operand_builder builder (
        .issue           (issue),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .forwarded_store (forwarded_store),
        .alu_inputs      (alu_inputs),
        .ls_inputs       (ls_inputs),
        .branch_inputs   (branch_inputs)
    );

endmodule

//--- verif/decode_issue_ref.svh
/*
 * Reference model for the decode and issue stage testbench
 * Instruction encoding, expected unit set, issue rule and payloads
 */
`ifndef DECODE_ISSUE_REF_SVH
`define DECODE_ISSUE_REF_SVH

// Kinds: 0 reg arith, 1 imm arith, 2 LUI, 3 AUIPC, 4 load, 5 store,
// 6 branch, 7 JAL, 8 JALR
function automatic decode_pkg::instr_t encode_instr(int kind, logic [31:0] a, logic [31:0] b);
    logic [2:0] f3;
    logic [11:0] imm;
    logic [6:0] f7;
    f3 = a[14:12];
    imm = b[11:0];
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && a[30]) ? 7'b0100000 : 7'b0;
    case (kind)
        0: return {f7, a[24:20], a[19:15], f3, a[11:7], 7'b0110011};
        1: begin
            if (f3 == 3'd1)
                imm = {7'b0, b[4:0]};
            else if (f3 == 3'd5)
                imm = {1'b0, a[30], 5'b0, b[4:0]};
            return {imm, a[19:15], f3, a[11:7], 7'b0010011};
        end
        2: return {b[31:12], a[11:7], 7'b0110111};
        3: return {b[31:12], a[11:7], 7'b0010111};
        4: return {imm, a[19:15], f3, a[11:7], 7'b0000011};
        5: return {imm[11:5], a[24:20], a[19:15], f3, imm[4:0], 7'b0100011};
        6: begin
            // No branch uses funct3 010 or 011
            f3[1] = f3[1] & f3[2];
            return {b[11], b[10:5], a[24:20], a[19:15], f3, b[4:1], b[0], 7'b1100011};
        end
        7: return {b[31:12], a[11:7], 7'b1101111};
        default: return {imm, a[19:15], 3'b000, a[11:7], 7'b1100111};
    endcase
endfunction

function automatic decode_pkg::unit_vec_t ref_units(decode_pkg::instr_t i);
    case (i[6:0])
        7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111: return 3'b001;
        7'b0000011, 7'b0100011: return 3'b100;
        7'b1100011: return 3'b010;
        default: return 3'b011;
    endcase
endfunction

function automatic logic ref_uses_rs1(decode_pkg::instr_t i);
    return !(i[6:0] inside {7'b0110111, 7'b0010111, 7'b1101111});
endfunction

function automatic logic ref_uses_rs2(decode_pkg::instr_t i);
    return i[6:0] inside {7'b0110011, 7'b0100011, 7'b1100011};
endfunction

// All needed units ready, a busy rs2 only matters outside load/store
function automatic logic ref_issue_ok(decode_pkg::instr_t i, decode_pkg::unit_vec_t ready,
                                      logic b1, logic b2);
    logic c1;
    logic c2;
    decode_pkg::unit_vec_t need;
    c1 = b1 && ref_uses_rs1(i) && i[19:15] != 0;
    c2 = b2 && ref_uses_rs2(i) && i[24:20] != 0;
    need = ref_units(i);
    for (int u = 0; u < 3; u++) begin
        if (need[u] && !(ready[u] && !c1 && (u == decode_pkg::LS_UNIT || !c2)))
            return 1'b0;
    end
    return 1'b1;
endfunction

function automatic decode_pkg::alu_inputs_t ref_alu(decode_pkg::instr_t i, decode_pkg::xlen_t pc,
                                                  decode_pkg::xlen_t r1, decode_pkg::xlen_t r2);
    decode_pkg::alu_inputs_t e;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0] f3;
    logic adder_only;
    f3 = i[14:12];
    adder_only = i[6:0] inside {7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111};
    case (i[6:0])
        7'b0110011: begin a = r1; b = r2; end
        7'b0010011: begin a = r1; b = {{20{i[31]}}, i[31:20]}; end
        7'b0110111: begin a = 0; b = {i[31:12], 12'b0}; end
        7'b0010111: begin a = pc; b = {i[31:12], 12'b0}; end
        default: begin a = pc; b = 32'd4; end
    endcase
    e.in1 = {a[31] & ~f3[0], a};
    e.in2 = {b[31] & ~f3[0], b};
    e.shifter_in = r1;
    e.shift_amount = i[5] ? r2[4:0] : i[24:20];
    e.arith = r1[31] & i[30];
    if (adder_only || !(f3 inside {3'd4, 3'd6, 3'd7}))
        e.logic_op = decode_pkg::ALU_LOGIC_ADD;
    else if (f3 == 3'd4)
        e.logic_op = decode_pkg::ALU_LOGIC_XOR;
    else if (f3 == 3'd6)
        e.logic_op = decode_pkg::ALU_LOGIC_OR;
    else
        e.logic_op = decode_pkg::ALU_LOGIC_AND;
    e.slt_path = !adder_only && (f3 inside {3'd2, 3'd3});
    e.subtract = e.slt_path || (!adder_only && f3 == 3'd0 && i[30] && i[5]);
    e.shifter_path = !adder_only && (f3 inside {3'd1, 3'd5});
    e.lshift = ~f3[2];
    return e;
endfunction

function automatic decode_pkg::ls_inputs_t ref_ls(decode_pkg::instr_t i, decode_pkg::xlen_t r1,
                                                decode_pkg::xlen_t r2, logic fwd);
    decode_pkg::ls_inputs_t e;
    e.rs1 = r1;
    e.rs2 = r2;
    e.store = i[6:0] == 7'b0100011;
    e.load = i[6:0] == 7'b0000011;
    e.offset = e.store ? {i[31:25], i[11:7]} : i[31:20];
    e.fn3 = i[14:12];
    e.forwarded_store = fwd;
    return e;
endfunction

function automatic decode_pkg::branch_inputs_t ref_branch(decode_pkg::instr_t i,
        decode_pkg::xlen_t pc, decode_pkg::xlen_t r1, decode_pkg::xlen_t r2);
    decode_pkg::branch_inputs_t e;
    e.rs1 = r1;
    e.rs2 = r2;
    e.issue_pc = pc;
    e.jal = i[6:0] == 7'b1101111;
    e.jalr = i[6:0] == 7'b1100111;
    if (e.jalr)
        e.pc_offset = {{9{i[31]}}, i[31:20]};
    else if (e.jal)
        e.pc_offset = {i[31], i[19:12], i[20], i[30:21], 1'b0};
    else
        e.pc_offset = {{8{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    e.fn3 = i[14:12];
    e.use_signed = !(i[14:12] inside {3'd6, 3'd7});
    return e;
endfunction

`endif

//--- verif/decode_issue_tb.sv
/*
 * Testbench for the decode and issue stage
 * Clock, reset, LCG stimulus, expected-result queue, compare tasks,
 * cycle timeout and summary
 */
module decode_issue_tb;
    timeunit 1ns;
    timeprecision 100ps;

    `include "decode_issue_ref.svh"

    localparam int TEST_CYCLES = 150;
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT_CYCLES = 4 * (NUM_TESTS * TEST_CYCLES + 16);

    typedef struct {
        decode_pkg::instr_t instr;
        decode_pkg::xlen_t  pc;
        decode_pkg::xlen_t  rs1v;
        decode_pkg::xlen_t  rs2v;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    decode_pkg::decode_packet_t decode;
    logic decode_advance;
    decode_pkg::xlen_t rs1_data;
    decode_pkg::xlen_t rs2_data;
    logic rs1_busy;
    logic rs2_busy;
    decode_pkg::unit_vec_t unit_ready;
    logic issue_hold;
    logic flush;
    decode_pkg::unit_vec_t issue_to;
    logic instruction_issued;
    decode_pkg::alu_inputs_t alu_inputs;
    decode_pkg::ls_inputs_t ls_inputs;
    decode_pkg::branch_inputs_t branch_inputs;

    logic [31:0] seed = 32'h0823_846f;
    entry_t q[$];
    entry_t cur;
    entry_t e;
    logic last_accepted = 1'b0;
    logic exp_iss;
    logic exp_adv;
    logic fwd;
    decode_pkg::unit_vec_t units;
    int errors = 0;
    int issued = 0;
    int flushed = 0;
    int cycles = 0;

    decode_issue UUT (.*);

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Random numbers
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic chance(int pct);
        return ((lcg_next() >> 16) % 100) < pct;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_units(decode_pkg::unit_vec_t got, decode_pkg::unit_vec_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: issue_to got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_alu(decode_pkg::alu_inputs_t got, decode_pkg::alu_inputs_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: alu_inputs got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_ls(decode_pkg::ls_inputs_t got, decode_pkg::ls_inputs_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: ls_inputs got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_branch(decode_pkg::branch_inputs_t got,
                                  decode_pkg::branch_inputs_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: branch_inputs got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Checker runs on the falling edge where inputs and outputs are stable
    always @(negedge clk) begin
        if (!rst) begin
            exp_iss = q.size() != 0 && !issue_hold && !flush
                && ref_issue_ok(q[0].instr, unit_ready, rs1_busy, rs2_busy);
            exp_adv = decode.valid && !issue_hold && (q.size() == 0 || exp_iss);
            compare_bit("instruction_issued", instruction_issued, exp_iss);
            compare_bit("decode_advance", decode_advance, exp_adv);
            // No unit may take anything in a cycle without issue
            if (!exp_iss)
                compare_units(issue_to, '0);
            if (instruction_issued && q.size() != 0) begin
                e = q.pop_front();
                units = ref_units(e.instr);
                fwd = rs2_busy && e.instr[6:0] == 7'b0100011 && e.instr[24:20] != 0;
                compare_units(issue_to, units);
                if (units[decode_pkg::ALU_UNIT])
                    compare_alu(alu_inputs, ref_alu(e.instr, e.pc, e.rs1v, e.rs2v));
                if (units[decode_pkg::LS_UNIT])
                    compare_ls(ls_inputs, ref_ls(e.instr, e.rs1v, e.rs2v, fwd));
                if (units[decode_pkg::BRANCH_UNIT])
                    compare_branch(branch_inputs, ref_branch(e.instr, e.pc, e.rs1v, e.rs2v));
                issued++;
            end else if (flush && q.size() != 0) begin
                // Held instruction is dropped at this edge
                void'(q.pop_front());
                flushed++;
            end
            last_accepted = decode.valid && decode_advance;
            if (last_accepted)
                q.push_back(cur);
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d instructions still waiting",
                     cycles, q.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    task automatic drive_cycle(logic [8:0] kinds, int busy_pct, int stall_pct,
                               int hold_pct, int flush_pct);
        int kind;
        logic keep;
        keep = decode.valid && !last_accepted;
        if (!keep) begin
            kind = (lcg_next() >> 8) % 9;
            while (!kinds[kind])
                kind = (lcg_next() >> 8) % 9;
            cur.instr = encode_instr(kind, lcg_next(), lcg_next());
            cur.pc = cur.pc + 32'd4;
            cur.rs1v = lcg_next();
            cur.rs2v = lcg_next();
        end
        flush = chance(flush_pct);
        decode.valid = !flush && (keep || chance(75));
        decode.pc = cur.pc;
        decode.instruction = cur.instr;
        rs1_busy = chance(busy_pct);
        rs2_busy = chance(busy_pct);
        unit_ready = {!chance(stall_pct), !chance(stall_pct), !chance(stall_pct)};
        issue_hold = chance(hold_pct);
        rs1_data = q.size() != 0 ? q[0].rs1v : lcg_next();
        rs2_data = q.size() != 0 ? q[0].rs2v : lcg_next();
    endtask

    task automatic run_test(string name, logic [8:0] kinds, int busy_pct, int stall_pct,
                            int hold_pct, int flush_pct);
        int err0;
        int iss0;
        int fl0;
        err0 = errors;
        iss0 = issued;
        fl0 = flushed;
        repeat (TEST_CYCLES) begin
            @(posedge clk);
            #0.5;
            drive_cycle(kinds, busy_pct, stall_pct, hold_pct, flush_pct);
        end
        // Drain with everything free
        @(posedge clk);
        #0.5;
        drive_cycle(kinds, 0, 0, 0, 0);
        decode.valid = 1'b0;
        repeat (2) @(posedge clk);
        while (q.size() != 0) begin
            #0.5;
            rs1_data = q[0].rs1v;
            rs2_data = q[0].rs2v;
            @(posedge clk);
        end
        $display("%s: %0d issued, %0d flushed, %0d errors", name, issued - iss0,
                 flushed - fl0, errors - err0);
    endtask

    initial begin
        rst = 1'b1;
        decode = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        unit_ready = '1;
        issue_hold = 1'b0;
        flush = 1'b0;
        cur.pc = lcg_next() & 32'hffff_fffc;
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;

        run_test("alu operations", 9'b000001111, 0, 0, 0, 0);
        run_test("loads and stores", 9'b000110000, 0, 0, 0, 0);
        run_test("branches and jumps", 9'b111000000, 0, 0, 0, 0);
        run_test("operand hazards", 9'h1ff, 40, 0, 0, 0);
        run_test("back-pressure and hold", 9'h1ff, 10, 40, 20, 0);
        run_test("flush", 9'h1ff, 20, 20, 0, 10);

        $display("Total: %0d issued, %0d flushed, %0d errors", issued, flushed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+verif
verilog/decode_pkg.sv
verilog/instruction_decoder.sv
verilog/issue_stage.sv
verilog/operand_builder.sv
verilog/decode_issue.sv
verif/decode_issue_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= decode_issue_tb
RTL_TOP   ?= decode_issue
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
RTL_FILES ?= verilog/decode_pkg.sv verilog/instruction_decoder.sv \
             verilog/issue_stage.sv verilog/operand_builder.sv verilog/decode_issue.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

lint:
	$(VERILATOR) --lint-only $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
